//--- tb.f
rtl/lsu_pkg.sv
rtl/lsu_addr_stage.sv
rtl/lsu_fwd_merge.sv
rtl/lsu_load_align.sv
rtl/lsu_pipe_top.sv
verif/tb_lsu_pipe.sv

//--- Makefile
# Verilator build and run of the load/store pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_pipe
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
SRCS      := $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
EXE       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: compile
	./$(EXE) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_lsu_pipe.sv
/* Load/store pipe testbench with clock, reset, L1D memory and store
   queue forwarding models, random stimulus, expected-output pipeline and checks */

module tb_lsu_pipe;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINE_BYTES   = 16;
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RUN_CYCLES   = 3000;
  localparam int DRAIN_MAX    = 20;

  typedef struct packed {
    logic                         valid;
    logic [lsu_pkg::ROB_TAG_W-1:0] tag;
    logic                         is_load;
    lsu_pkg::mem_size_e           size;
    logic                         uns;
    logic [lsu_pkg::RD_W-1:0]     rd;
    logic [lsu_pkg::PADDR_W-1:0]  addr;
    lsu_pkg::except_e             exc;
    logic [lsu_pkg::XLEN_W-1:0]   st_data;
  } inst_t;

  logic                 i_clk = 1'b0;
  logic                 i_reset_n;
  logic                 i_flush;
  lsu_pkg::issue_t      i_ex0_issue;
  lsu_pkg::l1d_resp_t   i_l1d_resp;
  lsu_pkg::fwd_resp_t   i_fwd_resp;
  lsu_pkg::l1d_req_t    o_l1d_req;
  lsu_pkg::st_update_t  o_st_update;
  lsu_pkg::fwd_req_t    o_fwd_req;
  lsu_pkg::replay_t     o_replay;
  lsu_pkg::done_t       o_ex3_done;
  lsu_pkg::wr_t         o_ex3_wr;

  // Expected pipeline with one entry per stage
  inst_t                next_issue;
  inst_t                m_ex1;
  inst_t                m_ex2;
  inst_t                m_ex3;
  logic [63:0]          m_ex3_data;
  lsu_pkg::l1d_req_t    last_req;

  lsu_pkg::l1d_req_t    exp_l1d_req;
  lsu_pkg::st_update_t  exp_st_update;
  lsu_pkg::fwd_req_t    exp_fwd_req;
  lsu_pkg::replay_t     exp_replay;
  lsu_pkg::done_t       exp_done;
  lsu_pkg::wr_t         exp_wr;

  int seed = 32'hdbb2;
  int check_errs = 0;
  int other_errs = 0;
  int n_wr = 0;
  int n_cover_miss = 0;
  int n_replay = 0;
  int n_ld_exc = 0;
  int n_st_exc = 0;
  int n_store = 0;
  int n_rd0 = 0;
  int n_flush = 0;

  always #HALF_PERIOD i_clk = ~i_clk;

  lsu_pipe_top #(
    .LINE_BYTES (LINE_BYTES)
  ) dut (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_ex0_issue (i_ex0_issue),
    .i_l1d_resp  (i_l1d_resp),
    .i_fwd_resp  (i_fwd_resp),
    .o_l1d_req   (o_l1d_req),
    .o_st_update (o_st_update),
    .o_fwd_req   (o_fwd_req),
    .o_replay    (o_replay),
    .o_ex3_done  (o_ex3_done),
    .o_ex3_wr    (o_ex3_wr)
  );

  // --------------------------------------------------------------------------
  // Reference rules
  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    return a[7:0] ^ 8'h5a;
  endfunction

  function automatic logic load_noexc(input inst_t e);
    return e.valid && e.is_load && (e.exc == lsu_pkg::EXC_NONE);
  endfunction

  function automatic logic [7:0] access_mask(input inst_t e);
    logic [7:0] m;
    logic [2:0] pos;
    m = '0;
    for (int i = 0; i < (1 << e.size); i++) begin
      pos = 3'(e.addr + 32'(i));
      m[pos] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic is_covered(input inst_t e, input logic [7:0] dw);
    return (access_mask(e) & ~dw) == 8'h00;
  endfunction

  // Bytes in address order followed by sign or zero fill
  function automatic logic [63:0] load_result(input inst_t e, input lsu_pkg::fwd_resp_t f);
    logic [63:0] v;
    logic [2:0]  pos;
    int          nb;
    nb = 1 << e.size;
    v  = '0;
    for (int i = 0; i < nb; i++) begin
      pos = 3'(e.addr + 32'(i));
      v[i*8 +: 8] = f.fwd_dw[pos] ? f.data[pos*8 +: 8] : mem_byte(e.addr + 32'(i));
    end
    if (!e.uns) begin
      for (int j = nb * 8; j < 64; j++) begin
        v[j] = v[nb*8-1];
      end
    end
    return v;
  endfunction

  always_comb begin
    exp_l1d_req   = '0;
    exp_st_update = '0;
    exp_fwd_req   = '0;
    exp_replay    = '0;
    exp_done      = '0;
    exp_wr        = '0;
    if (m_ex1.valid && m_ex1.exc == lsu_pkg::EXC_NONE) begin
      if (m_ex1.is_load) begin
        exp_l1d_req.valid = 1'b1;
        exp_l1d_req.paddr = m_ex1.addr & ~32'(LINE_BYTES - 1);
      end else begin
        exp_st_update.valid   = 1'b1;
        exp_st_update.rob_tag = m_ex1.tag;
        exp_st_update.paddr   = m_ex1.addr;
        exp_st_update.size    = m_ex1.size;
        exp_st_update.data    = m_ex1.st_data;
      end
    end
    if (load_noexc(m_ex2)) begin
      exp_fwd_req.valid     = 1'b1;
      exp_fwd_req.paddr     = {m_ex2.addr[31:3], 3'b000};
      exp_fwd_req.byte_mask = access_mask(m_ex2);
      exp_replay.valid      = !i_l1d_resp.hit && !is_covered(m_ex2, i_fwd_resp.fwd_dw);
      exp_replay.rob_tag    = m_ex2.tag;
      exp_replay.paddr      = m_ex2.addr;
    end
    if (m_ex3.valid) begin
      exp_done.valid       = 1'b1;
      exp_done.rob_tag     = m_ex3.tag;
      exp_done.except_code = m_ex3.exc;
      exp_done.tval        = (m_ex3.exc != lsu_pkg::EXC_NONE) ? m_ex3.addr : '0;
      exp_wr.valid         = load_noexc(m_ex3) && (m_ex3.rd != '0);
      exp_wr.rd            = m_ex3.rd;
      exp_wr.data          = m_ex3_data;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  task automatic log_mismatch(input string test, input logic [127:0] expv,
                              input logic [127:0] actv);
    check_errs++;
    $display("[FAIL] %s: expected %0h, actual %0h", test, expv, actv);
  endtask

  a_l1d_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_l1d_req.valid ? (o_l1d_req == exp_l1d_req) : !o_l1d_req.valid)
    else log_mismatch("l1d_req", 128'($sampled(exp_l1d_req)), 128'($sampled(o_l1d_req)));

  a_st_update: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_st_update.valid ? (o_st_update == exp_st_update) : !o_st_update.valid)
    else log_mismatch("st_update", 128'($sampled(exp_st_update)),
                      128'($sampled(o_st_update)));

  a_fwd_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_fwd_req.valid ? (o_fwd_req == exp_fwd_req) : !o_fwd_req.valid)
    else log_mismatch("fwd_req", 128'($sampled(exp_fwd_req)), 128'($sampled(o_fwd_req)));

  a_replay: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_replay.valid ? (o_replay == exp_replay) : !o_replay.valid)
    else log_mismatch("replay", 128'($sampled(exp_replay)), 128'($sampled(o_replay)));

  a_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_done.valid ? (o_ex3_done == exp_done) : !o_ex3_done.valid)
    else log_mismatch("ex3_done", 128'($sampled(exp_done)), 128'($sampled(o_ex3_done)));

  a_wr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_wr.valid ? (o_ex3_wr == exp_wr) : !o_ex3_wr.valid)
    else log_mismatch("ex3_wr", 128'($sampled(exp_wr)), 128'($sampled(o_ex3_wr)));

  // --------------------------------------------------------------------------
  // Model step that mirrors the rising edge just passed
  task automatic advance_model();
    logic covered;
    if (!i_reset_n) begin
      m_ex1      = '0;
      m_ex2      = '0;
      m_ex3      = '0;
      m_ex3_data = '0;
    end else begin
      covered = is_covered(m_ex2, i_fwd_resp.fwd_dw);
      if (exp_replay.valid)
        n_replay++;
      if (i_flush && (next_issue.valid || m_ex1.valid || m_ex2.valid))
        n_flush++;
      m_ex3       = m_ex2;
      m_ex3.valid = m_ex2.valid && !i_flush &&
                    !(load_noexc(m_ex2) && !i_l1d_resp.hit && !covered);
      m_ex3_data  = load_result(m_ex2, i_fwd_resp);
      if (m_ex3.valid) begin
        if (m_ex3.exc == lsu_pkg::EXC_LD_MISALIGN) n_ld_exc++;
        if (m_ex3.exc == lsu_pkg::EXC_ST_MISALIGN) n_st_exc++;
        if (!m_ex3.is_load && m_ex3.exc == lsu_pkg::EXC_NONE) n_store++;
        if (load_noexc(m_ex3)) begin
          if (m_ex3.rd == '0) n_rd0++;
          else n_wr++;
          if (!i_l1d_resp.hit) n_cover_miss++;  // Fully forwarded
        end
      end
      m_ex2       = m_ex1;
      m_ex2.valid = m_ex1.valid && !i_flush;
      m_ex1       = next_issue;
      m_ex1.valid = next_issue.valid && !i_flush;
    end
  endtask

  task automatic drive_cycle(input bit issue_en);
    lsu_pkg::issue_t  iss;
    lsu_pkg::ld_fmt_t ld;
    lsu_pkg::st_fmt_t st;
    inst_t            e;
    logic [11:0]      off;
    logic [63:0]      rs1;
    int               nb;
    // L1D answers the request of the previous cycle
    i_l1d_resp.hit = 1'($random(seed));
    for (int i = 0; i < 16; i++) begin
      i_l1d_resp.data[i*8 +: 8] = mem_byte(last_req.paddr + 32'(i));
    end
    last_req          = o_l1d_req;
    i_fwd_resp.fwd_dw = 8'($random(seed));
    i_fwd_resp.data   = {$random(seed), $random(seed)};
    i_flush           = issue_en && (($random(seed) & 15) == 0);

    e         = '0;
    e.valid   = issue_en && (($random(seed) & 3) != 0);
    e.tag     = 6'($random(seed));
    e.is_load = 1'($random(seed));
    e.size    = lsu_pkg::mem_size_e'($random(seed) & 3);
    e.uns     = e.is_load && (e.size != lsu_pkg::D) && 1'($random(seed));
    e.rd      = 5'($random(seed));
    e.st_data = {$random(seed), $random(seed)};
    nb        = 1 << e.size;
    off       = 12'($random(seed)) & ~12'(nb - 1);
    rs1       = {$random(seed), $random(seed)};
    if (($random(seed) & 7) != 0)
      rs1[2:0] = rs1[2:0] & ~3'(nb - 1);  // Mostly aligned base
    e.addr = rs1[31:0] + {{20{off[11]}}, off};
    if ((e.addr & 32'(nb - 1)) != 0)
      e.exc = e.is_load ? lsu_pkg::EXC_LD_MISALIGN : lsu_pkg::EXC_ST_MISALIGN;
    else
      e.exc = lsu_pkg::EXC_NONE;

    iss = '0;
    if (e.is_load) begin
      ld.imm      = off;
      ld.rs1      = 5'($random(seed));
      ld.funct3   = {e.uns, e.size};
      ld.rd       = e.rd;
      ld.opcode   = lsu_pkg::OPC_LOAD;
      iss.inst.ld = ld;
    end else begin
      st.imm_hi   = off[11:5];
      st.rs2      = 5'($random(seed));
      st.rs1      = 5'($random(seed));
      st.funct3   = {1'b0, e.size};
      st.imm_lo   = off[4:0];
      st.opcode   = lsu_pkg::OPC_STORE;
      iss.inst.st = st;
    end
    iss.valid    = e.valid;
    iss.rob_tag  = e.tag;
    iss.rs1_data = rs1;
    iss.st_data  = e.st_data;
    i_ex0_issue  = iss;
    next_issue   = e;
  endtask

  task automatic require_reached(input string what, input int count);
    if (count == 0) begin
      other_errs++;
      $display("Stimulus never produced this case: %s", what);
    end
  endtask

  // --------------------------------------------------------------------------
  initial begin : stimulus
    int t;
    i_reset_n   = 1'b0;
    i_flush     = 1'b0;
    i_ex0_issue = '0;
    i_l1d_resp  = '0;
    i_fwd_resp  = '0;
    next_issue  = '0;
    last_req    = '0;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge i_clk);
      advance_model();
    end
    i_reset_n = 1'b1;

    for (int c = 0; c < RUN_CYCLES; c++) begin
      @(negedge i_clk);
      advance_model();
      drive_cycle(1'b1);
    end

    // Bounded drain
    t = 0;
    while ((m_ex1.valid || m_ex2.valid || m_ex3.valid || next_issue.valid) &&
           t < DRAIN_MAX) begin
      @(negedge i_clk);
      advance_model();
      drive_cycle(1'b0);
      t++;
    end
    if (m_ex1.valid || m_ex2.valid || m_ex3.valid) begin
      other_errs++;
      $display("Timeout: pipe still busy after %0d drain cycles", DRAIN_MAX);
    end
    @(negedge i_clk);

    require_reached("load write", n_wr);
    require_reached("covered load on miss", n_cover_miss);
    require_reached("replay", n_replay);
    require_reached("misaligned load", n_ld_exc);
    require_reached("misaligned store", n_st_exc);
    require_reached("aligned store", n_store);
    require_reached("load to x0", n_rd0);
    require_reached("flush of a live entry", n_flush);

    $display("Check errors: %0d, other errors: %0d", check_errs, other_errs);
    if (check_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- rtl/lsu_pipe_top.sv
/* Load/store execution pipe, EX0 to EX3
   Address stage, forwarding merge and load alignment */

module lsu_pipe_top #(
  parameter int LINE_BYTES = lsu_pkg::DEF_LINE_BYTES  // 8 or 16
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  lsu_pkg::issue_t      i_ex0_issue,
  input  lsu_pkg::l1d_resp_t   i_l1d_resp,
  input  lsu_pkg::fwd_resp_t   i_fwd_resp,
  output lsu_pkg::l1d_req_t    o_l1d_req,
  output lsu_pkg::st_update_t  o_st_update,
  output lsu_pkg::fwd_req_t    o_fwd_req,
  output lsu_pkg::replay_t     o_replay,
  output lsu_pkg::done_t       o_ex3_done,
  output lsu_pkg::wr_t         o_ex3_wr
);

  lsu_pkg::ex2_entry_t              w_ex2;
  logic [lsu_pkg::XLEN_W-1:0]       w_merged_data;
  logic                             w_load_ok;

  lsu_addr_stage #(
    .LINE_BYTES (LINE_BYTES)
  ) u_addr_stage (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_ex0_issue (i_ex0_issue),
    .o_l1d_req   (o_l1d_req),
    .o_st_update (o_st_update),
    .o_ex2       (w_ex2)
  );

  lsu_fwd_merge #(
    .LINE_BYTES (LINE_BYTES)
  ) u_fwd_merge (
    .i_ex2         (w_ex2),
    .i_l1d_resp    (i_l1d_resp),
    .i_fwd_resp    (i_fwd_resp),
    .o_fwd_req     (o_fwd_req),
    .o_replay      (o_replay),
    .o_merged_data (w_merged_data),
    .o_load_ok     (w_load_ok)
  );

  lsu_load_align u_load_align (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_ex2         (w_ex2),
    .i_merged_data (w_merged_data),
    .i_load_ok     (w_load_ok),
    .o_ex3_done    (o_ex3_done),
    .o_ex3_wr      (o_ex3_wr)
  );

endmodule

//--- rtl/lsu_load_align.sv
/* EX2 load size and sign extension, EX3 register,
   done report and register write */

module lsu_load_align (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_flush,
  input  lsu_pkg::ex2_entry_t         i_ex2,
  input  logic [lsu_pkg::XLEN_W-1:0]  i_merged_data,
  input  logic                        i_load_ok,
  output lsu_pkg::done_t              o_ex3_done,
  output lsu_pkg::wr_t                o_ex3_wr
);

  localparam int XW = lsu_pkg::XLEN_W;

  logic [XW-1:0]        w_ext;
  logic                 w_sx;
  logic                 w_capture;
  logic                 w_exc;
  lsu_pkg::ex2_entry_t  r_ex3;
  logic [XW-1:0]        r_ex3_data;

  always_comb begin
    w_sx = ~i_ex2.is_unsigned;
    case (i_ex2.size)
      lsu_pkg::B: w_ext = {{(XW-8){w_sx & i_merged_data[7]}}, i_merged_data[7:0]};
      lsu_pkg::H: w_ext = {{(XW-16){w_sx & i_merged_data[15]}}, i_merged_data[15:0]};
      lsu_pkg::W: w_ext = {{(XW-32){w_sx & i_merged_data[31]}}, i_merged_data[31:0]};
      default:    w_ext = i_merged_data;
    endcase
  end

  // Replayed loads drop out here
  assign w_capture = i_ex2.valid & ~i_flush &
                     ~(i_ex2.is_load & (i_ex2.except_code == lsu_pkg::EXC_NONE) & ~i_load_ok);

  // ---------------------------------------------------------------------------
  // EX3
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3 <= '0;
    end else begin
      r_ex3       <= i_ex2;
      r_ex3.valid <= w_capture;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_data <= '0;
    end else begin
      r_ex3_data <= w_ext;
    end
  end

  assign w_exc = (r_ex3.except_code != lsu_pkg::EXC_NONE);

  assign o_ex3_done.valid       = r_ex3.valid;
  assign o_ex3_done.rob_tag     = r_ex3.rob_tag;
  assign o_ex3_done.except_code = r_ex3.except_code;
  assign o_ex3_done.tval        = w_exc ? r_ex3.paddr : '0;

  assign o_ex3_wr.valid = r_ex3.valid & r_ex3.is_load & ~w_exc & (r_ex3.rd != '0);  // x0 never written
  assign o_ex3_wr.rd    = r_ex3.rd;
  assign o_ex3_wr.data  = r_ex3_data;

endmodule

//--- rtl/lsu_fwd_merge.sv
/* EX2 store queue forwarding request, byte merge with the L1D line,
   coverage check and replay request */

module lsu_fwd_merge #(
  parameter int LINE_BYTES = lsu_pkg::DEF_LINE_BYTES
) (
  input  lsu_pkg::ex2_entry_t         i_ex2,
  input  lsu_pkg::l1d_resp_t          i_l1d_resp,
  input  lsu_pkg::fwd_resp_t          i_fwd_resp,
  output lsu_pkg::fwd_req_t           o_fwd_req,
  output lsu_pkg::replay_t            o_replay,
  output logic [lsu_pkg::XLEN_W-1:0]  o_merged_data,
  output logic                        o_load_ok
);

  localparam int WORDS  = LINE_BYTES / 8;
  localparam int WSEL_W = $clog2(lsu_pkg::L1D_LINE_W / lsu_pkg::XLEN_W);

  logic                        w_active;
  logic [7:0]                  w_size_mask;
  logic [7:0]                  w_byte_mask;
  logic [WSEL_W-1:0]           w_word_sel;
  logic [lsu_pkg::XLEN_W-1:0]  w_line_word;
  logic [lsu_pkg::XLEN_W-1:0]  w_merged;
  logic                        w_covered;

  // Aligned load in EX2
  assign w_active = i_ex2.valid & i_ex2.is_load & (i_ex2.except_code == lsu_pkg::EXC_NONE);

  always_comb begin
    case (i_ex2.size)
      lsu_pkg::B: w_size_mask = 8'h01;
      lsu_pkg::H: w_size_mask = 8'h03;
      lsu_pkg::W: w_size_mask = 8'h0f;
      default:    w_size_mask = 8'hff;
    endcase
  end

  assign w_byte_mask = w_size_mask << i_ex2.paddr[2:0];

  assign o_fwd_req.valid     = w_active;
  assign o_fwd_req.paddr     = {i_ex2.paddr[lsu_pkg::PADDR_W-1:3], 3'b000};
  assign o_fwd_req.byte_mask = w_byte_mask;

  // ---------------------------------------------------------------------------
  // An 8-byte line always uses word 0
  assign w_word_sel  = i_ex2.paddr[3 +: WSEL_W] & WSEL_W'(WORDS - 1);
  assign w_line_word = i_l1d_resp.data[w_word_sel * lsu_pkg::XLEN_W +: lsu_pkg::XLEN_W];

  for (genvar b = 0; b < 8; b++) begin : g_byte
    assign w_merged[b*8 +: 8] = (w_byte_mask[b] & i_fwd_resp.fwd_dw[b]) ?
                                i_fwd_resp.data[b*8 +: 8] : w_line_word[b*8 +: 8];
  end

  assign w_covered = &(~w_byte_mask | i_fwd_resp.fwd_dw);

  assign o_merged_data = w_merged >> {i_ex2.paddr[2:0], 3'b000};  // Low-aligned
  assign o_load_ok     = i_l1d_resp.hit | w_covered;

  // Miss that forwarding cannot fill
  assign o_replay.valid   = w_active & ~i_l1d_resp.hit & ~w_covered;
  assign o_replay.rob_tag = i_ex2.rob_tag;
  assign o_replay.paddr   = i_ex2.paddr;

endmodule

//--- rtl/lsu_addr_stage.sv
/* EX1 issue register, decode, address generation and misalign check,
   L1D read request, store queue update and EX2 entry register */

module lsu_addr_stage #(
  parameter int LINE_BYTES = lsu_pkg::DEF_LINE_BYTES
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  lsu_pkg::issue_t      i_ex0_issue,
  output lsu_pkg::l1d_req_t    o_l1d_req,
  output lsu_pkg::st_update_t  o_st_update,
  output lsu_pkg::ex2_entry_t  o_ex2
);

  localparam int OFF_W = $clog2(LINE_BYTES);

  lsu_pkg::issue_t              r_ex1;
  lsu_pkg::lsu_inst_u           w_inst;
  logic                         w_is_load;
  logic                         w_is_store;
  logic [11:0]                  w_offset;
  lsu_pkg::mem_size_e           w_size;
  logic [lsu_pkg::PADDR_W-1:0]  w_addr;
  logic                         w_misalign;
  lsu_pkg::except_e             w_except;
  lsu_pkg::ex2_entry_t          w_ex2_next;
  lsu_pkg::ex2_entry_t          r_ex2;

  // ---------------------------------------------------------------------------
  // EX1
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1 <= '0;
    end else begin
      r_ex1       <= i_ex0_issue;
      r_ex1.valid <= i_ex0_issue.valid & ~i_flush;
    end
  end

  assign w_inst     = r_ex1.inst;
  assign w_is_load  = (w_inst.ld.opcode == lsu_pkg::OPC_LOAD);
  assign w_is_store = (w_inst.st.opcode == lsu_pkg::OPC_STORE);

  // S-type splits the offset around rd
  assign w_offset = w_is_store ? {w_inst.st.imm_hi, w_inst.st.imm_lo} : w_inst.ld.imm;
  assign w_size   = lsu_pkg::mem_size_e'(w_inst.ld.funct3[1:0]);

  assign w_addr = r_ex1.rs1_data[lsu_pkg::PADDR_W-1:0] +
                  {{(lsu_pkg::PADDR_W-12){w_offset[11]}}, w_offset};

  always_comb begin
    case (w_size)
      lsu_pkg::H: w_misalign = w_addr[0];
      lsu_pkg::W: w_misalign = |w_addr[1:0];
      lsu_pkg::D: w_misalign = |w_addr[2:0];
      default:    w_misalign = 1'b0;
    endcase
  end

  assign w_except = !w_misalign ? lsu_pkg::EXC_NONE :
                    w_is_load   ? lsu_pkg::EXC_LD_MISALIGN :
                                  lsu_pkg::EXC_ST_MISALIGN;

  // L1D line read for aligned loads only
  assign o_l1d_req.valid = r_ex1.valid & w_is_load & ~w_misalign;
  assign o_l1d_req.paddr = {w_addr[lsu_pkg::PADDR_W-1:OFF_W], {OFF_W{1'b0}}};

  assign o_st_update.valid   = r_ex1.valid & w_is_store & ~w_misalign;
  assign o_st_update.rob_tag = r_ex1.rob_tag;
  assign o_st_update.paddr   = w_addr;
  assign o_st_update.size    = w_size;
  assign o_st_update.data    = r_ex1.st_data;

  // ---------------------------------------------------------------------------
  // EX2 entry
  always_comb begin
    w_ex2_next.valid       = r_ex1.valid & ~i_flush;
    w_ex2_next.rob_tag     = r_ex1.rob_tag;
    w_ex2_next.rd          = w_inst.ld.rd;
    w_ex2_next.size        = w_size;
    w_ex2_next.is_unsigned = w_inst.ld.funct3[2];
    w_ex2_next.is_load     = w_is_load;
    w_ex2_next.paddr       = w_addr;  // No translation
    w_ex2_next.except_code = w_except;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2 <= '0;
    end else begin
      r_ex2 <= w_ex2_next;
    end
  end

  assign o_ex2 = r_ex2;

  a_ex1_opcode: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex1.valid |-> (w_is_load || w_is_store))
    else $error("EX1 entry with opcode %b", w_inst.ld.opcode);

endmodule

//--- rtl/lsu_pkg.sv
/* Shared widths, size and exception enums, opcode constants,
   instruction union and port structs of the load/store pipe */

package lsu_pkg;

  localparam int XLEN_W         = 64;
  localparam int PADDR_W        = 32;
  localparam int ROB_TAG_W      = 6;
  localparam int RD_W           = 5;
  localparam int DEF_LINE_BYTES = 16;
  localparam int L1D_LINE_W     = 16 * 8;  // Widest line carried on the bus

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [1:0] {B = 2'b00, H = 2'b01, W = 2'b10, D = 2'b11} mem_size_e;

  typedef enum logic [1:0] {EXC_NONE, EXC_LD_MISALIGN, EXC_ST_MISALIGN} except_e;

  // ---------------------------------------------------------------------------
  // I-type and S-type layouts of the instruction word
  typedef struct packed {
    logic [11:0]     imm;
    logic [4:0]      rs1;
    logic [2:0]      funct3;
    logic [RD_W-1:0] rd;
    logic [6:0]      opcode;
  } ld_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } st_fmt_t;

  typedef union packed {
    ld_fmt_t ld;
    st_fmt_t st;
  } lsu_inst_u;

  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob_tag;
    lsu_inst_u            inst;
    logic [XLEN_W-1:0]    rs1_data;
    logic [XLEN_W-1:0]    st_data;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob_tag;
    logic [RD_W-1:0]      rd;
    mem_size_e            size;
    logic                 is_unsigned;
    logic                 is_load;
    logic [PADDR_W-1:0]   paddr;
    except_e              except_code;
  } ex2_entry_t;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;  // Line aligned
  } l1d_req_t;

  typedef struct packed {
    logic                  hit;
    logic [L1D_LINE_W-1:0] data;
  } l1d_resp_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob_tag;
    logic [PADDR_W-1:0]   paddr;
    mem_size_e            size;
    logic [XLEN_W-1:0]    data;
  } st_update_t;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;  // 8-byte word address
    logic [7:0]         byte_mask;
  } fwd_req_t;

  typedef struct packed {
    logic [7:0]        fwd_dw;
    logic [XLEN_W-1:0] data;
  } fwd_resp_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob_tag;
    logic [PADDR_W-1:0]   paddr;
  } replay_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] rob_tag;
    except_e              except_code;
    logic [PADDR_W-1:0]   tval;
  } done_t;

  typedef struct packed {
    logic              valid;
    logic [RD_W-1:0]   rd;
    logic [XLEN_W-1:0] data;
  } wr_t;

endpackage
